// ==== list.f ====
+incdir+include
source/mfifo_addr_pkg.sv
source/mfifo_data_pkg.sv
source/mfifo_config_check.sv
source/mfifo_ctrl.sv
source/mfifo_ram.sv
source/mfifo_staging.sv
source/mfifo_top.sv
bench/mfifo_tb.sv

// ==== bench/mfifo_tb.sv ====
`timescale 1ns/1ps

`include "mfifo_params.svh"

module mfifo_tb;

  localparam int NUM_ROWS     = 6;
  localparam int RESET_CYCLES = 10;
  localparam int REF_SLOTS    = 64;

  logic                                         clk;
  logic                                         rst_n;
  mfifo_addr_pkg::addr_t [`MFIFO_NUM_FIFOS-1:0] config_base;
  mfifo_addr_pkg::addr_t [`MFIFO_NUM_FIFOS-1:0] config_bound;
  logic                                         config_error;
  logic                                         push_valid;
  logic                                         push_ready;
  mfifo_data_pkg::data_t                        push_data;
  mfifo_addr_pkg::fifo_id_t                     push_fifo_id;
  logic [`MFIFO_NUM_FIFOS-1:0]                  push_full;
  logic [`MFIFO_NUM_FIFOS-1:0]                  pop_valid;
  logic [`MFIFO_NUM_FIFOS-1:0]                  pop_ready;
  mfifo_data_pkg::data_t [`MFIFO_NUM_FIFOS-1:0] pop_data;
  logic [`MFIFO_NUM_FIFOS-1:0]                  pop_empty;

  // Configuration table with one row per reset
  mfifo_addr_pkg::addr_t [`MFIFO_NUM_FIFOS-1:0] row_base   [NUM_ROWS];
  mfifo_addr_pkg::addr_t [`MFIFO_NUM_FIFOS-1:0] row_bound  [NUM_ROWS];
  logic                                         row_error  [NUM_ROWS];
  int                                           row_cycles [NUM_ROWS];

  // Reference model with one circular queue per FIFO
  mfifo_data_pkg::data_t ref_mem  [`MFIFO_NUM_FIFOS][REF_SLOTS];
  int                    ref_head [`MFIFO_NUM_FIFOS];
  int                    ref_tail [`MFIFO_NUM_FIFOS];

  logic [`MFIFO_NUM_FIFOS-1:0]                  hold_prev;
  mfifo_data_pkg::data_t [`MFIFO_NUM_FIFOS-1:0] data_prev;
  logic                                         push_done;
  logic                                         last_push_ready;
  logic [`MFIFO_NUM_FIFOS-1:0]                  last_push_full;
  logic                                         cfg_on;
  logic                                         empty_check_on;
  int                                           cur_row;
  logic [31:0]                                  lcg_state;

  mfifo_top mfifo_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .config_base  (config_base),
    .config_bound (config_bound),
    .config_error (config_error),
    .push_valid   (push_valid),
    .push_ready   (push_ready),
    .push_data    (push_data),
    .push_fifo_id (push_fifo_id),
    .push_full    (push_full),
    .pop_valid    (pop_valid),
    .pop_ready    (pop_ready),
    .pop_data     (pop_data),
    .pop_empty    (pop_empty)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {8'h00, lcg_state[31:8]};
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("** Error at time %0t: %s (got 0x%0h, expected 0x%0h)",
               $time, what, actual, expected);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic set_row(input int r, input int b0, input int e0, input int b1,
                         input int e1, input int b2, input int e2, input int b3,
                         input int e3, input logic err, input int cycles);
    row_base[r][0]  = mfifo_addr_pkg::addr_t'(b0);
    row_bound[r][0] = mfifo_addr_pkg::addr_t'(e0);
    row_base[r][1]  = mfifo_addr_pkg::addr_t'(b1);
    row_bound[r][1] = mfifo_addr_pkg::addr_t'(e1);
    row_base[r][2]  = mfifo_addr_pkg::addr_t'(b2);
    row_bound[r][2] = mfifo_addr_pkg::addr_t'(e2);
    row_base[r][3]  = mfifo_addr_pkg::addr_t'(b3);
    row_bound[r][3] = mfifo_addr_pkg::addr_t'(e3);
    row_error[r]    = err;
    row_cycles[r]   = cycles;
  endtask

  task automatic fill_table();
    // Row, base and bound of FIFO 0 to 3, expected error, traffic cycles
    set_row(0, 0, 7, 8, 15, 16, 23, 24, 31, 1'b0, 300);
    set_row(1, 0, 3, 6, 19, 20, 20, 25, 31, 1'b0, 300);
    set_row(2, 0, 0, 1, 1, 2, 2, 3, 31, 1'b0, 300);
    // Inverted region, overlap, then neighbors sharing address 7
    set_row(3, 0, 7, 10, 8, 16, 23, 24, 31, 1'b1, 30);
    set_row(4, 0, 9, 8, 15, 16, 23, 24, 31, 1'b1, 30);
    set_row(5, 0, 7, 7, 15, 16, 23, 24, 31, 1'b1, 30);
  endtask

  function automatic int queued_words();
    int total;
    total = 0;
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      total += ref_tail[i] - ref_head[i];
    end
    return total;
  endfunction

  // Sampled late in the cycle, just before the edge that completes handshakes
  task automatic observe();
    if (cfg_on) begin
      check(32'(config_error), 32'(row_error[cur_row]), "config_error");
      if (row_error[cur_row]) begin
        check(32'(push_ready), 32'd0, "push_ready under config error");
        check(32'(pop_valid), 32'd0, "pop_valid under config error");
      end
    end
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      if (hold_prev[i]) begin
        check(32'(pop_valid[i]), 32'd1, $sformatf("pop_valid held on FIFO %0d", i));
        check(32'(pop_data[i]), 32'(data_prev[i]), $sformatf("pop_data held on FIFO %0d", i));
      end
      if (empty_check_on) begin
        check(32'(pop_empty[i]), 32'(ref_head[i] == ref_tail[i]),
              $sformatf("pop_empty of FIFO %0d", i));
      end
      if (pop_valid[i] && pop_ready[i]) begin
        check(32'(ref_tail[i] != ref_head[i]), 32'd1, $sformatf("pop from empty FIFO %0d", i));
        check(32'(pop_data[i]), 32'(ref_mem[i][ref_head[i] % REF_SLOTS]),
              $sformatf("pop_data of FIFO %0d", i));
        ref_head[i]++;
      end
      hold_prev[i] = pop_valid[i] && !pop_ready[i];
      data_prev[i] = pop_data[i];
    end
    push_done = push_valid && push_ready;
    if (push_done) begin
      ref_mem[push_fifo_id][ref_tail[push_fifo_id] % REF_SLOTS] = push_data;
      ref_tail[push_fifo_id]++;
    end
    last_push_ready = push_ready;
    last_push_full  = push_full;
  endtask

  task automatic finish_cycle();
    #17;
    observe();
    @(posedge clk);
    #2;
  endtask

  task automatic apply_reset(input int r);
    rst_n        = 1'b0;
    config_base  = row_base[r];
    config_bound = row_bound[r];
    push_valid   = 1'b0;
    pop_ready    = '0;
    cfg_on       = 1'b0;
    push_done    = 1'b0;
    hold_prev    = '0;
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      ref_head[i] = 0;
      ref_tail[i] = 0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    #17;
    check(32'(push_ready), 32'd0, "push_ready after reset");
    check(32'(pop_valid), 32'd0, "pop_valid after reset");
    check(32'(push_full), 32'd0, "push_full after reset");
    check(32'(pop_empty), 32'((1 << `MFIFO_NUM_FIFOS) - 1), "pop_empty after reset");
    @(posedge clk);
    #2;
    cfg_on = 1'b1;
  endtask

  task automatic idle_empty_check();
    push_valid = 1'b0;
    pop_ready  = '0;
    repeat (3) finish_cycle();
    empty_check_on = 1'b1;
    finish_cycle();
    empty_check_on = 1'b0;
  endtask

  task automatic run_traffic(input int r);
    logic [31:0] rnd;
    for (int c = 0; c < row_cycles[r]; c++) begin
      if ((c % 50) == 49 && (push_done || !push_valid)) begin
        idle_empty_check();
      end
      if (push_done || !push_valid) begin
        push_valid   = (lcg_next() % 4) != 0;
        push_fifo_id = mfifo_addr_pkg::fifo_id_t'(lcg_next() % `MFIFO_NUM_FIFOS);
        push_data    = mfifo_data_pkg::data_t'(lcg_next());
      end else if (row_error[r]) begin
        // Nothing is accepted here, so release and try another id
        push_valid = 1'b0;
      end
      rnd       = lcg_next();
      pop_ready = rnd[`MFIFO_NUM_FIFOS-1:0];
      finish_cycle();
    end
  endtask

  task automatic drain();
    pop_ready = '1;
    // Let a pending push land first
    while (push_valid && !push_done && !row_error[cur_row]) begin
      finish_cycle();
    end
    push_valid = 1'b0;
    while (queued_words() != 0) begin
      finish_cycle();
    end
    idle_empty_check();
  endtask

  task automatic capacity_test(input int r);
    int f;
    int o;
    int size;
    int accepted;
    f            = r % `MFIFO_NUM_FIFOS;
    o            = (f + 1) % `MFIFO_NUM_FIFOS;
    size         = int'(row_bound[r][f]) - int'(row_base[r][f]) + 1;
    accepted     = 0;
    pop_ready    = '0;
    push_valid   = 1'b1;
    push_fifo_id = mfifo_addr_pkg::fifo_id_t'(f);
    push_data    = mfifo_data_pkg::data_t'(lcg_next());
    repeat (size + 4) begin
      finish_cycle();
      if (push_done) begin
        accepted++;
        push_data = mfifo_data_pkg::data_t'(lcg_next());
      end
    end
    // Region plus the staging slot
    check(accepted, size + 1, $sformatf("words accepted by stalled FIFO %0d", f));
    check(32'(last_push_full[f]), 32'd1, $sformatf("push_full of FIFO %0d", f));
    check(32'(last_push_ready), 32'd0, $sformatf("push_ready of full FIFO %0d", f));
    push_valid = 1'b0;
    finish_cycle();
    push_valid   = 1'b1;
    push_fifo_id = mfifo_addr_pkg::fifo_id_t'(o);
    push_data    = mfifo_data_pkg::data_t'(lcg_next());
    finish_cycle();
    check(32'(push_done), 32'd1, $sformatf("push to FIFO %0d beside a full one", o));
    drain();
  endtask

  initial begin
    rst_n           = 1'b0;
    push_valid      = 1'b0;
    push_data       = '0;
    push_fifo_id    = '0;
    pop_ready       = '0;
    lcg_state       = 32'd11490;
    cfg_on          = 1'b0;
    empty_check_on  = 1'b0;
    push_done       = 1'b0;
    hold_prev       = '0;
    data_prev       = '0;
    last_push_ready = 1'b0;
    last_push_full  = '0;
    cur_row         = 0;
    fill_table();
    config_base  = row_base[0];
    config_bound = row_bound[0];
    @(posedge clk);
    #2;
    for (int r = 0; r < NUM_ROWS; r++) begin
      cur_row = r;
      apply_reset(r);
      run_traffic(r);
      drain();
      if (!row_error[r]) begin
        capacity_test(r);
      end
    end
    $display("All tests passed");
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    longint budget;
    #1;
    budget = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      budget += row_cycles[r] + RESET_CYCLES;
    end
    budget = budget * 20 * 4;
    #(budget);
    $display("Watchdog expired at time %0t: the run hung before all rows finished", $time);
    $display("Some tests failed");
    $fatal(1);
  end

endmodule

// ==== source/mfifo_top.sv ====
`timescale 1ns/1ps

`include "mfifo_params.svh"

module mfifo_top (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  mfifo_addr_pkg::addr_t [`MFIFO_NUM_FIFOS-1:0] config_base,
  input  mfifo_addr_pkg::addr_t [`MFIFO_NUM_FIFOS-1:0] config_bound,
  output logic                                         config_error,
  input  logic                                         push_valid,
  output logic                                         push_ready,
  input  mfifo_data_pkg::data_t                        push_data,
  input  mfifo_addr_pkg::fifo_id_t                     push_fifo_id,
  output logic [`MFIFO_NUM_FIFOS-1:0]                  push_full,
  output logic [`MFIFO_NUM_FIFOS-1:0]                  pop_valid,
  input  logic [`MFIFO_NUM_FIFOS-1:0]                  pop_ready,
  output mfifo_data_pkg::data_t [`MFIFO_NUM_FIFOS-1:0] pop_data,
  output logic [`MFIFO_NUM_FIFOS-1:0]                  pop_empty
);

  // RAM write and read ports
  logic                     wr_en;
  mfifo_addr_pkg::addr_t    wr_addr;
  mfifo_data_pkg::data_t    wr_data;
  logic                     rd_en;
  mfifo_addr_pkg::addr_t    rd_addr;
  mfifo_data_pkg::data_t    rd_data;

  // Controller to staging
  logic                         rd_fire;
  mfifo_addr_pkg::fifo_id_t     rd_fifo_id;
  logic [`MFIFO_NUM_FIFOS-1:0]  slot_free;
  logic [`MFIFO_NUM_FIFOS-1:0]  ram_empty;

  mfifo_config_check mfifo_config_check_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .config_base  (config_base),
    .config_bound (config_bound),
    .config_error (config_error)
  );

  mfifo_ctrl mfifo_ctrl_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .config_base  (config_base),
    .config_bound (config_bound),
    .config_error (config_error),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .push_fifo_id (push_fifo_id),
    .push_ready   (push_ready),
    .push_full    (push_full),
    .slot_free    (slot_free),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .rd_fire      (rd_fire),
    .rd_fifo_id   (rd_fifo_id),
    .ram_empty    (ram_empty)
  );

  mfifo_ram mfifo_ram_inst (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  mfifo_staging mfifo_staging_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_fire    (rd_fire),
    .rd_fifo_id (rd_fifo_id),
    .rd_data    (rd_data),
    .ram_empty  (ram_empty),
    .slot_free  (slot_free),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .pop_data   (pop_data),
    .pop_empty  (pop_empty)
  );

endmodule

// ==== source/mfifo_staging.sv ====
`timescale 1ns/1ps

`include "mfifo_params.svh"

module mfifo_staging (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         rd_fire,
  input  mfifo_addr_pkg::fifo_id_t                     rd_fifo_id,
  input  mfifo_data_pkg::data_t                        rd_data,
  input  logic [`MFIFO_NUM_FIFOS-1:0]                  ram_empty,
  output logic [`MFIFO_NUM_FIFOS-1:0]                  slot_free,
  output logic [`MFIFO_NUM_FIFOS-1:0]                  pop_valid,
  input  logic [`MFIFO_NUM_FIFOS-1:0]                  pop_ready,
  output mfifo_data_pkg::data_t [`MFIFO_NUM_FIFOS-1:0] pop_data,
  output logic [`MFIFO_NUM_FIFOS-1:0]                  pop_empty
);

  mfifo_data_pkg::slot_state_e                 slot_state [`MFIFO_NUM_FIFOS];
  mfifo_data_pkg::data_t [`MFIFO_NUM_FIFOS-1:0] slot_data;
  logic [`MFIFO_NUM_FIFOS-1:0]                 fill_hit;

  always_comb begin
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      fill_hit[i]  = rd_fire && (rd_fifo_id == mfifo_addr_pkg::fifo_id_t'(i));
      pop_valid[i] = (slot_state[i] == mfifo_data_pkg::SLOT_HOLD);
      // Slot can take a read now if it is idle or its word leaves this cycle
      slot_free[i] = (slot_state[i] == mfifo_data_pkg::SLOT_EMPTY) ||
                     (pop_valid[i] && pop_ready[i]);
      pop_empty[i] = ram_empty[i] && (slot_state[i] == mfifo_data_pkg::SLOT_EMPTY);
    end
  end

  assign pop_data = slot_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
        slot_state[i] <= mfifo_data_pkg::SLOT_EMPTY;
      end
    end else begin
      for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
        case (slot_state[i])
          mfifo_data_pkg::SLOT_EMPTY: begin
            if (fill_hit[i]) begin
              slot_state[i] <= mfifo_data_pkg::SLOT_FILLING;
            end
          end
          mfifo_data_pkg::SLOT_FILLING: begin
            slot_state[i] <= mfifo_data_pkg::SLOT_HOLD;
          end
          mfifo_data_pkg::SLOT_HOLD: begin
            // Back to back refill when the next read fires with the pop
            if (pop_ready[i]) begin
              slot_state[i] <= fill_hit[i] ? mfifo_data_pkg::SLOT_FILLING
                                           : mfifo_data_pkg::SLOT_EMPTY;
            end
          end
          default: begin
            slot_state[i] <= mfifo_data_pkg::SLOT_EMPTY;
          end
        endcase
      end
    end
  end

  // Only the slot that fired last cycle is filling, so rd_data is its word
  always_ff @(posedge clk) begin
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      if (slot_state[i] == mfifo_data_pkg::SLOT_FILLING) begin
        slot_data[i] <= rd_data;
      end
    end
  end

endmodule

// ==== source/mfifo_ram.sv ====
`timescale 1ns/1ps

`include "mfifo_params.svh"

module mfifo_ram (
  input  logic                  clk,
  input  logic                  wr_en,
  input  mfifo_addr_pkg::addr_t wr_addr,
  input  mfifo_data_pkg::data_t wr_data,
  input  logic                  rd_en,
  input  mfifo_addr_pkg::addr_t rd_addr,
  output mfifo_data_pkg::data_t rd_data
);

  mfifo_data_pkg::data_t mem [`MFIFO_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read returns old contents on a same-edge write
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== source/mfifo_ctrl.sv ====
`timescale 1ns/1ps

`include "mfifo_params.svh"

module mfifo_ctrl (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  mfifo_addr_pkg::addr_t [`MFIFO_NUM_FIFOS-1:0] config_base,
  input  mfifo_addr_pkg::addr_t [`MFIFO_NUM_FIFOS-1:0] config_bound,
  input  logic                                         config_error,
  input  logic                                         push_valid,
  input  mfifo_data_pkg::data_t                        push_data,
  input  mfifo_addr_pkg::fifo_id_t                     push_fifo_id,
  output logic                                         push_ready,
  output logic [`MFIFO_NUM_FIFOS-1:0]                  push_full,
  input  logic [`MFIFO_NUM_FIFOS-1:0]                  slot_free,
  output logic                                         wr_en,
  output mfifo_addr_pkg::addr_t                        wr_addr,
  output mfifo_data_pkg::data_t                        wr_data,
  output logic                                         rd_en,
  output mfifo_addr_pkg::addr_t                        rd_addr,
  output logic                                         rd_fire,
  output mfifo_addr_pkg::fifo_id_t                     rd_fifo_id,
  output logic [`MFIFO_NUM_FIFOS-1:0]                  ram_empty
);

  mfifo_addr_pkg::addr_t  [`MFIFO_NUM_FIFOS-1:0] wr_ptr;
  mfifo_addr_pkg::addr_t  [`MFIFO_NUM_FIFOS-1:0] rd_ptr;
  mfifo_addr_pkg::count_t [`MFIFO_NUM_FIFOS-1:0] count;
  mfifo_addr_pkg::count_t [`MFIFO_NUM_FIFOS-1:0] region_size;
  mfifo_addr_pkg::fifo_id_t                      rr_ptr;

  logic                         run;
  logic                         push_fire;
  logic [`MFIFO_NUM_FIFOS-1:0]  push_hit;
  logic [`MFIFO_NUM_FIFOS-1:0]  read_hit;
  logic [`MFIFO_NUM_FIFOS-1:0]  rd_qual;

  // Step within a region, wrapping from bound back to base
  function automatic mfifo_addr_pkg::addr_t next_addr(
    input mfifo_addr_pkg::addr_t ptr,
    input mfifo_addr_pkg::addr_t base,
    input mfifo_addr_pkg::addr_t bound
  );
    if (ptr == bound) begin
      return base;
    end
    return ptr + 1'b1;
  endfunction

  always_comb begin
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      region_size[i] = mfifo_addr_pkg::count_t'(config_bound[i])
                     - mfifo_addr_pkg::count_t'(config_base[i]) + 1'b1;
      push_full[i]   = (count[i] == region_size[i]);
      ram_empty[i]   = (count[i] == '0);
      // A word written this cycle is not counted yet, so it is never read early
      rd_qual[i]     = !ram_empty[i] && slot_free[i];
    end
  end

  // Push side
  assign push_ready = run && !config_error && !push_full[push_fifo_id];
  assign push_fire  = push_valid && push_ready;
  assign wr_en      = push_fire;
  assign wr_addr    = wr_ptr[push_fifo_id];
  assign wr_data    = push_data;

  // Round robin search starting just after the last winner
  always_comb begin
    mfifo_addr_pkg::fifo_id_t cand;
    rd_fire    = 1'b0;
    rd_fifo_id = rr_ptr;
    for (int k = 1; k <= `MFIFO_NUM_FIFOS; k++) begin
      cand = mfifo_addr_pkg::fifo_id_t'((int'(rr_ptr) + k) % `MFIFO_NUM_FIFOS);
      if (!rd_fire && rd_qual[cand]) begin
        rd_fire    = 1'b1;
        rd_fifo_id = cand;
      end
    end
  end

  assign rd_en   = rd_fire;
  assign rd_addr = rd_ptr[rd_fifo_id];

  always_comb begin
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      push_hit[i] = push_fire && (push_fifo_id == mfifo_addr_pkg::fifo_id_t'(i));
      read_hit[i] = rd_fire && (rd_fifo_id == mfifo_addr_pkg::fifo_id_t'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run    <= 1'b0;
      rr_ptr <= mfifo_addr_pkg::fifo_id_t'(`MFIFO_NUM_FIFOS - 1);
      for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
        wr_ptr[i] <= config_base[i];
        rd_ptr[i] <= config_base[i];
        count[i]  <= '0;
      end
    end else begin
      // Hold pushes off until the checker result is registered
      run <= 1'b1;
      if (rd_fire) begin
        rr_ptr <= rd_fifo_id;
      end
      for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
        if (push_hit[i]) begin
          wr_ptr[i] <= next_addr(wr_ptr[i], config_base[i], config_bound[i]);
        end
        if (read_hit[i]) begin
          rd_ptr[i] <= next_addr(rd_ptr[i], config_base[i], config_bound[i]);
        end
        case ({push_hit[i], read_hit[i]})
          2'b10:   count[i] <= count[i] + 1'b1;
          2'b01:   count[i] <= count[i] - 1'b1;
          default: count[i] <= count[i];
        endcase
      end
    end
  end

endmodule

// ==== source/mfifo_config_check.sv ====
`timescale 1ns/1ps

`include "mfifo_params.svh"

module mfifo_config_check (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  mfifo_addr_pkg::addr_t [`MFIFO_NUM_FIFOS-1:0] config_base,
  input  mfifo_addr_pkg::addr_t [`MFIFO_NUM_FIFOS-1:0] config_bound,
  output logic                                         config_error
);

  logic error_d;

  always_comb begin
    error_d = 1'b0;

    // Each region must not be inverted
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      if (config_base[i] > config_bound[i]) begin
        error_d = 1'b1;
      end
    end

    // Regions must be ascending with no shared address
    for (int i = 0; i < `MFIFO_NUM_FIFOS - 1; i++) begin
      if (config_base[i+1] <= config_bound[i]) begin
        error_d = 1'b1;
      end
    end
  end

  // Table is static after reset, so the first registered value is final
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      config_error <= 1'b0;
    end else begin
      config_error <= error_d;
    end
  end

endmodule

// ==== source/mfifo_data_pkg.sv ====
`include "mfifo_params.svh"

package mfifo_data_pkg;

  // One payload word
  typedef logic [`MFIFO_WIDTH-1:0] data_t;

  // Output slot is idle, waiting on its RAM read or holding a word for the pop port
  typedef enum logic [1:0] {
    SLOT_EMPTY   = 2'd0,
    SLOT_FILLING = 2'd1,
    SLOT_HOLD    = 2'd2
  } slot_state_e;

endpackage

// ==== source/mfifo_addr_pkg.sv ====
`include "mfifo_params.svh"

package mfifo_addr_pkg;

  // Selects one logical FIFO
  typedef logic [$clog2(`MFIFO_NUM_FIFOS)-1:0] fifo_id_t;

  // RAM address, also used for region base and bound
  typedef logic [$clog2(`MFIFO_DEPTH)-1:0] addr_t;

  // Entries held in RAM by one FIFO, zero up to the full depth
  typedef logic [$clog2(`MFIFO_DEPTH+1)-1:0] count_t;

endpackage

// ==== include/mfifo_params.svh ====
`ifndef MFIFO_PARAMS_SVH
`define MFIFO_PARAMS_SVH

// Number of logical FIFOs sharing the RAM
`define MFIFO_NUM_FIFOS 4

// Entries in the shared RAM, split into one region per FIFO
`define MFIFO_DEPTH 32

// Bits per data word
`define MFIFO_WIDTH 16

`endif
